/* bench/classifierNetTb.sv */
`timescale 1ns/1ps

module classifierNetTb;

	import nnFormatPkg::*;
	import nnShapePkg::*;

	localparam int timeoutCycles = 500;
	localparam int pipeLatency = 7;

	// same trained values as the top level defaults, highest index first.
	localparam hiddenWeightsT hiddenWeights = {
		16'sd416, -16'sd192, -16'sd96, 16'sd288, 16'sd160, 16'sd224, 16'sd64, -16'sd320,
		16'sd96, 16'sd128, -16'sd288, 16'sd32, 16'sd384, -16'sd192, 16'sd160, 16'sd256,
		16'sd224, -16'sd64, 16'sd352, 16'sd160, -16'sd256, 16'sd96, 16'sd288, -16'sd128,
		-16'sd160, 16'sd256, 16'sd128, -16'sd224, 16'sd64, 16'sd320, -16'sd96, 16'sd192
	};
	localparam hiddenBiasT hiddenBias = {16'sd64, -16'sd32, 16'sd16, -16'sd48};
	localparam outputWeightsT outputWeights = {
		16'sd256, -16'sd128, 16'sd192, -16'sd64, -16'sd96, 16'sd320,
		16'sd64, 16'sd160, 16'sd128, 16'sd96, -16'sd224, 16'sd288
	};
	localparam outputBiasT outputBias = {-16'sd24, -16'sd40, -16'sd16};

	logic clk = 1'b0;
	logic reset;
	logic inValid;
	logic inReady;
	featureVecT features;
	logic outValid;
	logic outReady = 1'b1;
	classIndexT classIndex;
	activationT score;

	logic randomStall;
	logic latencyTag;
	int cycleCount = 0;
	int zeroSeen = 0;
	int satSeen = 0;
	int stallSeen = 0;

	// expected results in input order.
	classIndexT expIndexQ[$];
	activationT expScoreQ[$];
	int expCycleQ[$];
	logic expTimedQ[$];

	logic expAvail = 1'b0;
	classIndexT expIndex = '0;
	activationT expScore = '0;
	int expCycle = 0;
	logic expTimed = 1'b0;

	classifierNet #(
		.hiddenWeights(hiddenWeights),
		.hiddenBias(hiddenBias),
		.outputWeights(outputWeights),
		.outputBias(outputBias)
	) classifierNet_i (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.features(features),
		.outValid(outValid),
		.outReady(outReady),
		.classIndex(classIndex),
		.score(score)
	);

	always #10 clk = ~clk;

	task automatic endFailed();
		$display("Test failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic flagMismatch(input string name, input int expected, input int actual);
		$display("CHECK FAILED at time %0d ns: %s expected %0d, actual %0d",
			$time, name, expected, actual);
		endFailed();
	endtask

	task automatic abortWith(input string reason);
		$display("ERROR at time %0d ns: %s", $time, reason);
		endFailed();
	endtask

	// relu with clamp at the largest q8.8 value.
	function automatic activationT rectify(input longint sum);
		longint scaled;
		scaled = sum >>> fracBits;
		if (scaled < 0)
		begin
			return '0;
		end
		if (scaled > longint'(activationMax))
		begin
			return activationMax;
		end
		return activationT'(scaled);
	endfunction

	task automatic predict(input featureVecT f, output classIndexT bestIndex,
		output activationT bestScore);
		activationT hiddenAct [hiddenCount];
		activationT classAct [classCount];
		longint acc;
		for (int n = 0; n < hiddenCount; n++)
		begin
			acc = longint'($signed(hiddenBias[n])) * (longint'(1) << fracBits);
			for (int i = 0; i < inputCount; i++)
			begin
				acc += longint'($signed(f[i])) * longint'($signed(hiddenWeights[n*inputCount + i]));
			end
			hiddenAct[n] = rectify(acc);
		end
		for (int c = 0; c < classCount; c++)
		begin
			acc = longint'($signed(outputBias[c])) * (longint'(1) << fracBits);
			for (int j = 0; j < hiddenCount; j++)
			begin
				acc += longint'(hiddenAct[j]) * longint'($signed(outputWeights[c*hiddenCount + j]));
			end
			classAct[c] = rectify(acc);
		end
		// first maximum wins.
		bestIndex = '0;
		bestScore = classAct[0];
		for (int c = 1; c < classCount; c++)
		begin
			if (classAct[c] > bestScore)
			begin
				bestIndex = classIndexT'(c);
				bestScore = classAct[c];
			end
		end
	endtask

	// mostly small values, now and then the full range.
	function automatic featureVecT randomVector();
		featureVecT vec;
		for (int i = 0; i < inputCount; i++)
		begin
			if ($urandom % 8 == 0)
			begin
				vec[i] = activationT'($urandom);
			end
			else
			begin
				vec[i] = activationT'(int'($urandom % 2048) - 1024);
			end
		end
		return vec;
	endfunction

	task automatic sendVector(input featureVecT vec, input logic timed);
		int waited;
		logic accepted;
		inValid <= 1'b1;
		features <= vec;
		latencyTag <= timed;
		waited = 0;
		accepted = 1'b0;
		while (!accepted && waited < timeoutCycles)
		begin
			@(posedge clk);
			accepted = inReady;
			waited++;
		end
		if (!accepted)
		begin
			abortWith("inReady never went high for a pending input");
		end
	endtask

	task automatic waitDrained();
		int waited;
		waited = 0;
		while (expIndexQ.size() != 0 && waited < timeoutCycles)
		begin
			@(negedge clk);
			waited++;
		end
		if (expIndexQ.size() != 0)
		begin
			abortWith("outstanding results never came out");
		end
		else
		begin
			@(posedge clk);
		end
	endtask

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		outReady <= !randomStall || ($urandom % 3 != 0);
	end

	always @(posedge clk)
	begin : scoreboard
		classIndexT predIndex;
		activationT predScore;
		if (!reset)
		begin
			if (outValid && outReady && expIndexQ.size() != 0)
			begin
				void'(expIndexQ.pop_front());
				void'(expScoreQ.pop_front());
				void'(expCycleQ.pop_front());
				void'(expTimedQ.pop_front());
			end
			if (outValid && outReady && score == '0)
			begin
				zeroSeen++;
			end
			if (outValid && outReady && score == activationMax)
			begin
				satSeen++;
			end
			if (outValid && !outReady)
			begin
				stallSeen++;
			end
			if (inValid && inReady)
			begin
				predict(features, predIndex, predScore);
				expIndexQ.push_back(predIndex);
				expScoreQ.push_back(predScore);
				expCycleQ.push_back(cycleCount);
				expTimedQ.push_back(latencyTag);
			end
		end
	end

	// head of the queue, settled away from the rising edge.
	always @(negedge clk)
	begin
		expAvail <= (expIndexQ.size() != 0);
		if (expIndexQ.size() != 0)
		begin
			expIndex <= expIndexQ[0];
			expScore <= expScoreQ[0];
			expCycle <= expCycleQ[0];
			expTimed <= expTimedQ[0];
		end
	end

	resetClean: assert property (@(posedge clk) reset |=> !outValid && inReady)
		else abortWith("outValid high or inReady low right after reset");

	noExtraResult: assert property (@(posedge clk) disable iff (reset)
		outValid && outReady |-> expAvail)
		else abortWith("a result came out with no input outstanding");

	indexMatches: assert property (@(posedge clk) disable iff (reset)
		outValid && outReady && expAvail |-> classIndex == expIndex)
		else flagMismatch("classIndex", int'($sampled(expIndex)), int'($sampled(classIndex)));

	scoreMatches: assert property (@(posedge clk) disable iff (reset)
		outValid && outReady && expAvail |-> score == expScore)
		else flagMismatch("score", int'($sampled(expScore)), int'($sampled(score)));

	latencyMatches: assert property (@(posedge clk) disable iff (reset)
		outValid && outReady && expAvail && expTimed |-> cycleCount - expCycle == pipeLatency)
		else flagMismatch("latency", pipeLatency, $sampled(cycleCount) - $sampled(expCycle));

	stallHolds: assert property (@(posedge clk) disable iff (reset)
		outValid && !outReady |=> outValid && $stable(classIndex) && $stable(score))
		else abortWith("output changed or dropped while stalled");

	inReadyStalled: assert property (@(posedge clk) disable iff (reset)
		outValid && !outReady |-> !inReady)
		else abortWith("inReady high while the output is stalled");

	initial
	begin
		featureVecT cornerVec;
		void'($urandom(32'h542d7e47));
		reset <= 1'b1;
		inValid <= 1'b0;
		features <= '0;
		latencyTag <= 1'b0;
		randomStall <= 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// lone vector through an empty pipe.
		sendVector(randomVector(), 1'b1);
		inValid <= 1'b0;
		waitDrained();

		// all hidden neurons negative, then one saturating class.
		cornerVec = '0;
		cornerVec[7] = -16'sd512;
		cornerVec[3] = -16'sd512;
		cornerVec[2] = -16'sd512;
		sendVector(cornerVec, 1'b1);
		cornerVec = '0;
		cornerVec[3] = activationMax;
		sendVector(cornerVec, 1'b1);
		inValid <= 1'b0;
		waitDrained();

		repeat (40) sendVector(randomVector(), 1'b1);
		inValid <= 1'b0;
		waitDrained();

		// back-pressure with gaps on the input side.
		randomStall <= 1'b1;
		repeat (80)
		begin
			if ($urandom % 4 == 0)
			begin
				inValid <= 1'b0;
				@(posedge clk);
			end
			sendVector(randomVector(), 1'b0);
		end
		inValid <= 1'b0;
		waitDrained();
		randomStall <= 1'b0;

		if (zeroSeen > 0 && satSeen > 0 && stallSeen > 0)
		begin
			$display("Test passed");
			$finish;
		end
		else
		begin
			abortWith("a zero score, a saturated score or a stall was never seen");
		end
	end

endmodule

/* classifierNet.f */
hdl/nnFormatPkg.sv
hdl/nnShapePkg.sv
hdl/denseNeuron.sv
hdl/denseLayer.sv
hdl/classSelect.sv
hdl/classifierNet.sv
bench/classifierNetTb.sv

/* hdl/classSelect.sv */
`timescale 1ns/1ps

module classSelect (
	input logic clk,
	input logic reset,
	input logic scoreValid,
	input nnShapePkg::scoreVecT scores,
	input logic outReady,
	output logic advance,
	output logic outValid,
	output nnShapePkg::classIndexT classIndex,
	output nnFormatPkg::activationT score
);

	import nnFormatPkg::*;
	import nnShapePkg::*;

	classIndexT bestIndex;
	activationT bestScore;

	// strict compare keeps the lowest index on a tie.
	always_comb
	begin
		bestIndex = '0;
		bestScore = scores[0];
		for (int c = 1; c < classCount; c++)
		begin
			if ($signed(scores[c]) > $signed(bestScore))
			begin
				bestIndex = classIndexT'(c);
				bestScore = scores[c];
			end
		end
	end

	// whole pipeline moves unless a result is waiting.
	assign advance = !outValid || outReady;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outValid <= 1'b0;
		end
		else if (advance)
		begin
			outValid <= scoreValid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			classIndex <= bestIndex;
			score <= bestScore;
		end
	end

	resultStableWhileStalled: assert property (
		@(posedge clk) disable iff (reset)
		outValid && !outReady |=> $stable(classIndex) && $stable(score)
	);

endmodule

/* hdl/classifierNet.sv */
`timescale 1ns/1ps

module classifierNet #(
	// neuron 3 down to neuron 0, each from input 7 down to input 0.
	parameter nnShapePkg::hiddenWeightsT hiddenWeights = {
		16'sd416, -16'sd192, -16'sd96, 16'sd288,
		16'sd160, 16'sd224, 16'sd64, -16'sd320,
		16'sd96, 16'sd128, -16'sd288, 16'sd32,
		16'sd384, -16'sd192, 16'sd160, 16'sd256,
		16'sd224, -16'sd64, 16'sd352, 16'sd160,
		-16'sd256, 16'sd96, 16'sd288, -16'sd128,
		-16'sd160, 16'sd256, 16'sd128, -16'sd224,
		16'sd64, 16'sd320, -16'sd96, 16'sd192
	},
	parameter nnShapePkg::hiddenBiasT hiddenBias = {
		16'sd64, -16'sd32, 16'sd16, -16'sd48
	},
	// class 2 down to class 0, each from hidden 3 down to hidden 0.
	parameter nnShapePkg::outputWeightsT outputWeights = {
		16'sd256, -16'sd128, 16'sd192, -16'sd64,
		-16'sd96, 16'sd320, 16'sd64, 16'sd160,
		16'sd128, 16'sd96, -16'sd224, 16'sd288
	},
	parameter nnShapePkg::outputBiasT outputBias = {
		-16'sd24, -16'sd40, -16'sd16
	}
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input nnShapePkg::featureVecT features,
	output logic outValid,
	input logic outReady,
	output nnShapePkg::classIndexT classIndex,
	output nnFormatPkg::activationT score
);

	import nnShapePkg::*;

	logic advance;
	logic hiddenValid;
	hiddenVecT hidden;
	logic scoreValid;
	scoreVecT scores;

	// input is only accepted when the pipe moves.
	assign inReady = advance;

	denseLayer #(
		.inCount(inputCount),
		.outCount(hiddenCount),
		.layerWeights(hiddenWeights),
		.layerBias(hiddenBias)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.inValid(inValid),
		.inputs(features),
		.outValid(hiddenValid),
		.outputs(hidden)
	);

	denseLayer #(
		.inCount(hiddenCount),
		.outCount(classCount),
		.layerWeights(outputWeights),
		.layerBias(outputBias)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.inValid(hiddenValid),
		.inputs(hidden),
		.outValid(scoreValid),
		.outputs(scores)
	);

	classSelect classSelect_i (
		.clk(clk),
		.reset(reset),
		.scoreValid(scoreValid),
		.scores(scores),
		.outReady(outReady),
		.advance(advance),
		.outValid(outValid),
		.classIndex(classIndex),
		.score(score)
	);

endmodule

/* hdl/denseLayer.sv */
`timescale 1ns/1ps

module denseLayer #(
	parameter int inCount = 8,
	parameter int outCount = 4,
	parameter nnFormatPkg::weightT [outCount*inCount-1:0] layerWeights = '0,
	parameter nnFormatPkg::weightT [outCount-1:0] layerBias = '0
) (
	input logic clk,
	input logic reset,
	input logic advance,
	input logic inValid,
	input nnFormatPkg::activationT [inCount-1:0] inputs,
	output logic outValid,
	output nnFormatPkg::activationT [outCount-1:0] outputs
);

	localparam int stageCount = 3;

	// one bit per neuron stage.
	logic [stageCount-1:0] validPipe;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else if (advance)
		begin
			validPipe <= {validPipe[stageCount-2:0], inValid};
		end
	end

	assign outValid = validPipe[stageCount-1];

	for (genvar n = 0; n < outCount; n++)
	begin : neuron
		denseNeuron #(
			.inCount(inCount),
			.neuronWeights(layerWeights[n*inCount +: inCount]),
			.neuronBias(layerBias[n])
		) neuron_i (
			.clk(clk),
			.reset(reset),
			.advance(advance),
			.inputs(inputs),
			.activation(outputs[n])
		);
	end

	// nothing leaks out of the pipe right after reset.
	validClearAfterReset: assert property (
		@(posedge clk)
		reset |=> !outValid
	);

endmodule

/* hdl/denseNeuron.sv */
`timescale 1ns/1ps

module denseNeuron #(
	parameter int inCount = 8,
	parameter nnFormatPkg::weightT [inCount-1:0] neuronWeights = '0,
	parameter nnFormatPkg::weightT neuronBias = '0
) (
	input logic clk,
	input logic reset,
	input logic advance,
	input nnFormatPkg::activationT [inCount-1:0] inputs,
	output nnFormatPkg::activationT activation
);

	import nnFormatPkg::*;

	activationT [inCount-1:0] inputReg;
	accumT weightedSum;
	accumT sumReg;
	accumT shiftedSum;

	// bias is lifted to q16.16 so it lines up with the products.
	always_comb
	begin
		weightedSum = accumT'($signed(neuronBias)) <<< fracBits;
		for (int i = 0; i < inCount; i++)
		begin
			weightedSum += accumT'($signed(inputReg[i])) * accumT'($signed(neuronWeights[i]));
		end
	end

	assign shiftedSum = sumReg >>> fracBits;

	// three stages: inputs, sum, rectified value.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputReg <= '0;
			sumReg <= '0;
			activation <= '0;
		end
		else if (advance)
		begin
			inputReg <= inputs;
			sumReg <= weightedSum;
			if (shiftedSum < 0)
			begin
				activation <= '0;
			end
			else if (shiftedSum > accumT'(activationMax))
			begin
				activation <= activationMax;
			end
			else
			begin
				activation <= activationT'(shiftedSum);
			end
		end
	end

	// holds across stalls and reset release too.
	activationNonNegative: assert property (
		@(posedge clk) disable iff (reset)
		!activation[$bits(activationT)-1]
	);

endmodule

/* hdl/nnFormatPkg.sv */
package nnFormatPkg;

	// bit widths of the fixed-point formats.
	localparam int activationWidth = 16;
	localparam int weightWidth = 16;
	localparam int accumWidth = 32;

	// q16.16 back to q8.8.
	localparam int fracBits = 8;

	// q8.8 feature or neuron output.
	typedef logic signed [activationWidth-1:0] activationT;

	// q8.8 weight or bias.
	typedef logic signed [weightWidth-1:0] weightT;

	// q16.16 running sum of products.
	typedef logic signed [accumWidth-1:0] accumT;

	// saturation limit of the rectifier.
	localparam activationT activationMax = activationT'({1'b0, {(activationWidth-1){1'b1}}});

endpackage

/* hdl/nnShapePkg.sv */
package nnShapePkg;

	// layer sizes.
	localparam int inputCount = 8;
	localparam int hiddenCount = 4;
	localparam int classCount = 3;

	localparam int classIndexWidth = $clog2(classCount);

	typedef logic [classIndexWidth-1:0] classIndexT;

	// neuron n owns elements n*inCount up to n*inCount+inCount-1.
	typedef nnFormatPkg::weightT [inputCount*hiddenCount-1:0] hiddenWeightsT;
	typedef nnFormatPkg::weightT [hiddenCount-1:0] hiddenBiasT;

	typedef nnFormatPkg::weightT [hiddenCount*classCount-1:0] outputWeightsT;
	typedef nnFormatPkg::weightT [classCount-1:0] outputBiasT;

	// activation vectors between stages.
	typedef nnFormatPkg::activationT [inputCount-1:0] featureVecT;
	typedef nnFormatPkg::activationT [hiddenCount-1:0] hiddenVecT;
	typedef nnFormatPkg::activationT [classCount-1:0] scoreVecT;

endpackage

/* runSim.sh */
#!/bin/sh
# build the classifier testbench with verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f classifierNet.f \
	--top-module classifierNetTb \
	-Mdir obj_dir -o classifierNetSim \
	> build.log 2>&1 || { cat build.log; echo "build did not complete"; exit 1; }

./obj_dir/classifierNetSim > sim.log 2>&1
cat sim.log

# the log decides the result.
grep -q "Test failed" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "Test passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation finished cleanly"
exit 0
